// ==== Bender.yml ====
package:
  name: instr_decoder

sources:
  - verilog/decoder_pkg.sv
  - verilog/decode_fields_if.sv
  - verilog/operand_sel_if.sv
  - verilog/instr_capture.sv
  - verilog/decode_control.sv
  - verilog/operand_select.sv
  - verilog/decoder_top.sv
  - target: test
    files:
      - verif/decoder_checker.sv
      - verif/tb_decoder.sv

// ==== sim.f ====
verilog/decoder_pkg.sv
verilog/decode_fields_if.sv
verilog/operand_sel_if.sv
verilog/instr_capture.sv
verilog/decode_control.sv
verilog/operand_select.sv
verilog/decoder_top.sv
verif/decoder_checker.sv
verif/tb_decoder.sv

// ==== verif/decoder_checker.sv ====
module decoder_checker (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 flush,
    input  logic [decoder_pkg::WORD_WIDTH-1:0]   instr,
    input  logic [decoder_pkg::PC_WIDTH-1:0]     pc,
    input  logic [decoder_pkg::WORD_WIDTH-1:0]   src1,
    input  logic [decoder_pkg::WORD_WIDTH-1:0]   src2,
    input  logic act_branch_eq0, act_branch_gt0, act_branch_lt0, act_ialu_add,
    input  logic act_ialu_neg_src2, act_ialu_sll, act_ialu_sra, act_ialu_srl,
    input  logic act_incr_pc_is_res, act_jump_to_ialu_res, act_load_dmem, act_store_dmem,
    input  logic act_write_res_to_reg, act_write_src2_to_res,
    input  logic [2:0]                           cycle_in_instr,
    input  logic [decoder_pkg::WORD_WIDTH-1:0]   instr_out,
    input  logic [decoder_pkg::PC_WIDTH-1:0]     pc_out,
    input  logic [decoder_pkg::REG_IDX_WIDTH-1:0] res_reg_idx,
    input  logic [decoder_pkg::REG_IDX_WIDTH-1:0] src1_reg_idx,
    input  logic [decoder_pkg::REG_IDX_WIDTH-1:0] src2_reg_idx,
    input  logic [decoder_pkg::WORD_WIDTH-1:0]   src1_out,
    input  logic [decoder_pkg::WORD_WIDTH-1:0]   src2_out,
    input  logic [decoder_pkg::WORD_WIDTH-1:0]   src3_out,
    output int                                   errors,
    output int                                   checks
);
    timeunit 1ns;
    timeprecision 1ps;
    import decoder_pkg::*;

    typedef struct packed {
        act_t                  act;
        logic [WORD_WIDTH-1:0] op1;
        logic [WORD_WIDTH-1:0] op2;
        logic [WORD_WIDTH-1:0] op3;
        logic [2:0]            next_cycle;
    } expect_t;

    logic [WORD_WIDTH-1:0] last_word;
    logic [WORD_WIDTH-1:0] older_word;
    logic [PC_WIDTH-1:0]   last_pc;
    logic [PC_WIDTH-1:0]   older_pc;
    logic                  flush_seen;
    logic [2:0]            cycle_idx;
    logic [WORD_WIDTH-1:0] head;  // Word holding the opcode
    expect_t               exp;

    initial begin
        errors = 0;
        checks = 0;
    end

    // a and b are the live register values
    function automatic expect_t expected_decode(
        input logic flushed, input logic [2:0] cyc,
        input logic [WORD_WIDTH-1:0] w_prev, input logic [WORD_WIDTH-1:0] w_cur,
        input logic [PC_WIDTH-1:0] p_prev, input logic [PC_WIDTH-1:0] p_cur,
        input logic [WORD_WIDTH-1:0] a, input logic [WORD_WIDTH-1:0] b);
        expect_t               e;
        logic                  two;
        logic [WORD_WIDTH-1:0] w;
        e   = '0;
        two = (cyc == 3'd1);
        w   = two ? w_prev : w_cur;
        if (flushed)
            return e;
        case (w[3:0])
            OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA: begin
                e.act.ialu_add         = (w[3:0] == OP_ADD) || (w[3:0] == OP_SUB);
                e.act.ialu_neg_src2    = (w[3:0] == OP_SUB);
                e.act.ialu_sll         = (w[3:0] == OP_SLL);
                e.act.ialu_srl         = (w[3:0] == OP_SRL);
                e.act.ialu_sra         = (w[3:0] == OP_SRA);
                e.act.write_res_to_reg = 1'b1;
                e.op1 = a;
                e.op2 = b;
            end
            OP_U_TYPE: begin
                if (w[11:8] == U_LIL || (w[11:8] == U_LI && two)) begin
                    e.act.write_res_to_reg  = 1'b1;
                    e.act.write_src2_to_res = 1'b1;
                    e.op2 = (w[11:8] == U_LIL) ? {12'h000, w[15:12]} : w_cur;
                end else if (w[11:8] == U_LI) begin
                    e.next_cycle = 3'd1;
                end
            end
            OP_S_TYPE: begin
                if (w[7:4] <= S_BLT) begin
                    e.act.ialu_add   = 1'b1;
                    e.act.branch_eq0 = (w[7:4] == S_BEQ) || (w[7:4] == S_BGE);
                    e.act.branch_gt0 = (w[7:4] == S_BNEQ) || (w[7:4] == S_BGE);
                    e.act.branch_lt0 = (w[7:4] == S_BNEQ) || (w[7:4] == S_BLT);
                    e.act.ialu_neg_src2 = !two;  // Compare cycle
                    e.op1 = two ? w_cur : a;
                    e.op2 = two ? {4'h0, p_prev} : b;
                    e.next_cycle = two ? 3'd0 : 3'd1;
                end else if (w[7:4] == S_SH) begin
                    e.act.store_dmem        = 1'b1;
                    e.act.write_src2_to_res = 1'b1;
                    e.op2 = b;
                    e.op3 = a;
                end else if (w[7:4] == S_SHO && two) begin
                    e.act.ialu_add   = 1'b1;
                    e.act.store_dmem = 1'b1;
                    e.op1 = w_cur;
                    e.op2 = b;
                    e.op3 = a;
                end else if (w[7:4] == S_SHO) begin
                    e.next_cycle = 3'd1;
                end
            end
            OP_J_TYPE: begin
                if (w[15:12] == J_JALR || (w[15:12] == J_JAL && two)) begin
                    e.act.ialu_add         = 1'b1;
                    e.act.incr_pc_is_res   = 1'b1;
                    e.act.jump_to_ialu_res = 1'b1;
                    e.act.write_res_to_reg = 1'b1;
                    e.op1 = (w[15:12] == J_JAL) ? w_cur : a;
                    e.op2 = (w[15:12] == J_JAL) ? {4'h0, p_prev} : {4'h0, p_cur};
                end else if (w[15:12] == J_JAL) begin
                    e.next_cycle = 3'd1;
                end
            end
            OP_LH: begin
                e.act.load_dmem         = 1'b1;
                e.act.write_res_to_reg  = 1'b1;
                e.act.write_src2_to_res = 1'b1;
                e.op2 = a;
            end
            OP_LHO: begin
                if (two) begin
                    e.act.ialu_add         = 1'b1;
                    e.act.load_dmem        = 1'b1;
                    e.act.write_res_to_reg = 1'b1;
                    e.op1 = a;
                    e.op2 = w_cur;  // Offset word
                end else begin
                    e.next_cycle = 3'd1;
                end
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic check(input string name, input logic [WORD_WIDTH-1:0] expected,
                         input logic [WORD_WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0d ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            last_word  <= '0;
            older_word <= '0;
            last_pc    <= '0;
            older_pc   <= '0;
            flush_seen <= 1'b0;
            cycle_idx  <= '0;
        end else begin
            last_word  <= instr;
            older_word <= last_word;
            last_pc    <= pc;
            older_pc   <= last_pc;
            flush_seen <= flush;
            cycle_idx  <= exp.next_cycle;  // From the compare half a cycle earlier
        end
    end

    // Mid-cycle, inputs and outputs are both settled
    always @(negedge clock) begin
        if (!reset) begin
            exp  = expected_decode(flush_seen, cycle_idx, older_word, last_word,
                                   older_pc, last_pc, src1, src2);
            head = (cycle_idx == 3'd1) ? older_word : last_word;
            check("act_branch_eq0", exp.act.branch_eq0, act_branch_eq0);
            check("act_branch_gt0", exp.act.branch_gt0, act_branch_gt0);
            check("act_branch_lt0", exp.act.branch_lt0, act_branch_lt0);
            check("act_ialu_add", exp.act.ialu_add, act_ialu_add);
            check("act_ialu_neg_src2", exp.act.ialu_neg_src2, act_ialu_neg_src2);
            check("act_ialu_sll", exp.act.ialu_sll, act_ialu_sll);
            check("act_ialu_sra", exp.act.ialu_sra, act_ialu_sra);
            check("act_ialu_srl", exp.act.ialu_srl, act_ialu_srl);
            check("act_incr_pc_is_res", exp.act.incr_pc_is_res, act_incr_pc_is_res);
            check("act_jump_to_ialu_res", exp.act.jump_to_ialu_res, act_jump_to_ialu_res);
            check("act_load_dmem", exp.act.load_dmem, act_load_dmem);
            check("act_store_dmem", exp.act.store_dmem, act_store_dmem);
            check("act_write_res_to_reg", exp.act.write_res_to_reg, act_write_res_to_reg);
            check("act_write_src2_to_res", exp.act.write_src2_to_res, act_write_src2_to_res);
            check("cycle_in_instr", cycle_idx, cycle_in_instr);
            check("instr_out", last_word, instr_out);
            check("pc_out", last_pc, pc_out);
            check("res_reg_idx", head[7:4], res_reg_idx);
            check("src1_reg_idx", head[11:8], src1_reg_idx);
            check("src2_reg_idx", head[15:12], src2_reg_idx);
            check("src1_out", exp.op1, src1_out);
            check("src2_out", exp.op2, src2_out);
            check("src3_out", exp.op3, src3_out);
        end
    end

endmodule

// ==== verif/tb_decoder.sv ====
module tb_decoder;
    timeunit 1ns;
    timeprecision 1ps;
    import decoder_pkg::*;

    localparam int IDLE_LIMIT   = 8;    // Cycles allowed to get back to cycle index 0
    localparam int RANDOM_WORDS = 400;

    logic                     clock;
    logic                     reset;
    logic                     flush;
    logic [WORD_WIDTH-1:0]    instr;
    logic [PC_WIDTH-1:0]      pc;
    logic [WORD_WIDTH-1:0]    src1;
    logic [WORD_WIDTH-1:0]    src2;
    logic act_branch_eq0, act_branch_gt0, act_branch_lt0, act_ialu_add, act_ialu_neg_src2;
    logic act_ialu_sll, act_ialu_sra, act_ialu_srl, act_incr_pc_is_res, act_jump_to_ialu_res;
    logic act_load_dmem, act_store_dmem, act_write_res_to_reg, act_write_src2_to_res;
    logic [2:0]               cycle_in_instr;
    logic [WORD_WIDTH-1:0]    instr_out;
    logic [PC_WIDTH-1:0]      pc_out;
    logic [REG_IDX_WIDTH-1:0] res_reg_idx;
    logic [REG_IDX_WIDTH-1:0] src1_reg_idx;
    logic [REG_IDX_WIDTH-1:0] src2_reg_idx;
    logic [WORD_WIDTH-1:0]    src1_out;
    logic [WORD_WIDTH-1:0]    src2_out;
    logic [WORD_WIDTH-1:0]    src3_out;
    int                       errors;
    int                       checks;
    int                       seed;

    decoder_top DUT (.*);

    decoder_checker monitor (.*);

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // One word per clock, driven just after the edge
    task automatic send_word(input logic [WORD_WIDTH-1:0] word, input logic flush_in);
        @(posedge clock);
        #1;
        instr = word;
        pc    = pc + 1'b1;
        flush = flush_in;
        src1  = $random(seed);
        src2  = $random(seed);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Test failed");
        $finish;
    endtask

    // Bubbles until the decoder sits between instructions
    task automatic wait_idle();
        int n;
        n = 0;
        send_word(16'h0000, 1'b0);
        while (cycle_in_instr != 3'd0 && n < IDLE_LIMIT) begin
            send_word(16'h0000, 1'b0);
            n++;
        end
        if (cycle_in_instr != 3'd0)
            abort_run("Timeout: decoder never returned to cycle index 0");
    endtask

    initial begin
        logic [WORD_WIDTH-1:0] word;
        seed  = 38;
        reset = 1'b1;
        flush = 1'b0;
        instr = '0;
        pc    = '0;
        src1  = '0;
        src2  = '0;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        wait_idle();

        for (int op = OP_ADD; op <= OP_SRA; op++) begin
            word = $random(seed);
            send_word({word[15:4], 4'(op)}, 1'b0);
        end
        wait_idle();

        send_word({4'h0, U_LI, 4'h3, OP_U_TYPE}, 1'b0);
        send_word(16'hbeef, 1'b0);  // Immediate word
        send_word({4'ha, U_LIL, 4'h5, OP_U_TYPE}, 1'b0);
        wait_idle();

        for (int f = S_BEQ; f <= S_BLT; f++) begin
            send_word({4'h2, 4'h1, 4'(f), OP_S_TYPE}, 1'b0);
            send_word(16'(f * 16'h0111 + 16'h0040), 1'b0);  // Branch offset
            wait_idle();
        end

        send_word({4'h0, 4'h7, 4'h2, OP_LH}, 1'b0);
        send_word({4'h0, 4'h8, 4'h9, OP_LHO}, 1'b0);
        send_word(16'h0123, 1'b0);
        send_word({4'h4, 4'h6, S_SH, OP_S_TYPE}, 1'b0);
        send_word({4'h5, 4'hc, S_SHO, OP_S_TYPE}, 1'b0);
        send_word(16'h8000, 1'b0);
        wait_idle();

        send_word({J_JAL, 4'h0, 4'h1, OP_J_TYPE}, 1'b0);
        send_word(16'hfff0, 1'b0);
        send_word({J_JALR, 4'h5, 4'h1, OP_J_TYPE}, 1'b0);
        wait_idle();

        // Flush lands on the second word of LI and JAL
        send_word({4'h0, U_LI, 4'h3, OP_U_TYPE}, 1'b0);
        send_word(16'h1234, 1'b1);
        wait_idle();
        send_word({J_JAL, 4'h0, 4'h2, OP_J_TYPE}, 1'b0);
        send_word(16'h0010, 1'b1);
        wait_idle();

        for (int op = 11; op <= 15; op++)
            send_word({12'h5a5, 4'(op)}, 1'b0);
        send_word({4'h1, 4'h0, 4'h2, OP_U_TYPE}, 1'b0);
        send_word({4'h1, 4'h2, 4'hf, OP_S_TYPE}, 1'b0);
        send_word({4'h7, 4'h2, 4'h3, OP_J_TYPE}, 1'b0);
        wait_idle();

        repeat (RANDOM_WORDS) begin
            word = $random(seed);
            send_word(word, ($random(seed) & 7) == 0);
        end
        wait_idle();

        @(negedge clock);
        #1;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== verilog/decode_control.sv ====
module decode_control (
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    decode_fields_if.control    fields,
    operand_sel_if.control      sel,
    output decoder_pkg::act_t   act,
    output logic [2:0]          cycle_in_instr
);
    import decoder_pkg::*;

    logic       flush_q;
    logic [2:0] cycle_q;
    logic [2:0] cycle_next;
    logic       unknown;  // Encoding outside the table

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flush_q <= 1'b0;
            cycle_q <= '0;
        end else begin
            flush_q <= flush;
            cycle_q <= cycle_next;
        end
    end

    assign fields.second_cycle = (cycle_q == 3'd1);
    assign cycle_in_instr      = cycle_q;

    always_comb begin
        act          = '0;
        sel.src1_sel = SRC1_ZERO;
        sel.src2_sel = SRC2_ZERO;
        sel.src3_sel = SRC3_ZERO;
        cycle_next   = 3'd0;
        unknown      = 1'b0;

        if (!flush_q) begin
            case (fields.opcode)
                OP_NOP: cycle_next = 3'd0;  // Bubble

                OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA: begin
                    act.ialu_add         = fields.opcode inside {OP_ADD, OP_SUB};
                    act.ialu_neg_src2    = (fields.opcode == OP_SUB);
                    act.ialu_sll         = (fields.opcode == OP_SLL);
                    act.ialu_srl         = (fields.opcode == OP_SRL);
                    act.ialu_sra         = (fields.opcode == OP_SRA);
                    act.write_res_to_reg = 1'b1;
                    sel.src1_sel         = SRC1_REG1;
                    sel.src2_sel         = SRC2_REG2;
                end

                OP_U_TYPE: begin
                    case (fields.u_func)
                        U_LI: begin
                            if (fields.second_cycle) begin
                                act.write_res_to_reg  = 1'b1;
                                act.write_src2_to_res = 1'b1;
                                sel.src2_sel          = SRC2_IMM_B;
                            end else begin
                                cycle_next = 3'd1;  // Fetch the immediate word
                            end
                        end
                        U_LIL: begin
                            act.write_res_to_reg  = 1'b1;
                            act.write_src2_to_res = 1'b1;
                            sel.src2_sel          = SRC2_IMM_A;
                        end
                        default: unknown = 1'b1;
                    endcase
                end

                OP_S_TYPE: begin
                    case (fields.s_func)
                        S_BEQ, S_BNEQ, S_BGE, S_BLT: begin
                            act.branch_eq0 = fields.s_func inside {S_BEQ, S_BGE};
                            act.branch_gt0 = fields.s_func inside {S_BNEQ, S_BGE};
                            act.branch_lt0 = fields.s_func inside {S_BNEQ, S_BLT};
                            act.ialu_add   = 1'b1;
                            if (fields.second_cycle) begin
                                sel.src1_sel = SRC1_IMM_B;  // Target offset
                                sel.src2_sel = SRC2_PC_PREV;
                            end else begin
                                cycle_next        = 3'd1;
                                act.ialu_neg_src2 = 1'b1;  // Compare by subtraction
                                sel.src1_sel      = SRC1_REG1;
                                sel.src2_sel      = SRC2_REG2;
                            end
                        end
                        S_SH: begin
                            act.store_dmem        = 1'b1;
                            act.write_src2_to_res = 1'b1;
                            sel.src2_sel          = SRC2_REG2;
                            sel.src3_sel          = SRC3_REG1;
                        end
                        S_SHO: begin
                            if (fields.second_cycle) begin
                                act.ialu_add   = 1'b1;
                                act.store_dmem = 1'b1;
                                sel.src1_sel   = SRC1_IMM_B;  // Base address
                                sel.src2_sel   = SRC2_REG2;
                                sel.src3_sel   = SRC3_REG1;
                            end else begin
                                cycle_next = 3'd1;
                            end
                        end
                        default: unknown = 1'b1;
                    endcase
                end

                OP_J_TYPE: begin
                    case (fields.j_func)
                        J_JAL, J_JALR: begin
                            if (fields.j_func == J_JAL && !fields.second_cycle) begin
                                cycle_next = 3'd1;
                            end else begin
                                act.ialu_add         = 1'b1;
                                act.incr_pc_is_res   = 1'b1;
                                act.jump_to_ialu_res = 1'b1;
                                act.write_res_to_reg = 1'b1;
                                if (fields.j_func == J_JAL) begin
                                    sel.src1_sel = SRC1_IMM_B;
                                    sel.src2_sel = SRC2_PC_PREV;
                                end else begin
                                    sel.src1_sel = SRC1_REG1;
                                    sel.src2_sel = SRC2_PC_CUR;
                                end
                            end
                        end
                        default: unknown = 1'b1;
                    endcase
                end

                OP_LH: begin
                    act.load_dmem         = 1'b1;
                    act.write_res_to_reg  = 1'b1;
                    act.write_src2_to_res = 1'b1;
                    sel.src2_sel          = SRC2_REG1;  // Address rides on src2
                end

                OP_LHO: begin
                    if (fields.second_cycle) begin
                        act.ialu_add         = 1'b1;
                        act.load_dmem        = 1'b1;
                        act.write_res_to_reg = 1'b1;
                        sel.src1_sel         = SRC1_REG1;
                        sel.src2_sel         = SRC2_IMM_B;
                    end else begin
                        cycle_next = 3'd1;
                    end
                end

                default: unknown = 1'b1;
            endcase
        end
    end

    a_one_alu_op: assert property (@(posedge clock) disable iff (reset)
        $onehot0({act.ialu_add, act.ialu_sll, act.ialu_srl, act.ialu_sra}));

    a_cycle_range: assert property (@(posedge clock) disable iff (reset)
        cycle_q <= 3'd1);

    // Held first word always came from a known two-word opcode
    a_unknown_first_cycle: assert property (@(posedge clock) disable iff (reset)
        unknown |-> !fields.second_cycle);

endmodule

// ==== verilog/decode_fields_if.sv ====
interface decode_fields_if;
    import decoder_pkg::*;

    opcode_e opcode;
    s_func_e s_func;
    u_func_e u_func;
    j_func_e j_func;
    logic    second_cycle;  // Cycle index is 1

    modport capture (
        output opcode,
        output s_func,
        output u_func,
        output j_func,
        input  second_cycle
    );

    modport control (
        input  opcode,
        input  s_func,
        input  u_func,
        input  j_func,
        output second_cycle
    );

endinterface

// ==== verilog/decoder_pkg.sv ====
package decoder_pkg;

    localparam int WORD_WIDTH    = 16;
    localparam int PC_WIDTH      = 12;
    localparam int REG_IDX_WIDTH = 4;
    localparam int OPCODE_WIDTH  = 4;
    localparam int FUNC_WIDTH    = 4;
    localparam int IMM_A_WIDTH   = 4;

    // Root opcode in bits 3:0 of the first word
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_NOP    = 4'b0000,
        OP_U_TYPE = 4'b0001,
        OP_J_TYPE = 4'b0010,
        OP_S_TYPE = 4'b0011,
        OP_LH     = 4'b0100,  // Load half
        OP_LHO    = 4'b0101,  // Load half with offset word
        OP_ADD    = 4'b0110,
        OP_SUB    = 4'b0111,
        OP_SLL    = 4'b1000,
        OP_SRL    = 4'b1001,
        OP_SRA    = 4'b1010
    } opcode_e;

    // S-type function, bits 7:4
    typedef enum logic [FUNC_WIDTH-1:0] {
        S_BEQ  = 4'b0000,
        S_BNEQ = 4'b0001,
        S_BGE  = 4'b0010,
        S_BLT  = 4'b0011,
        S_SH   = 4'b0100,
        S_SHO  = 4'b0101
    } s_func_e;

    // U-type function, bits 11:8
    typedef enum logic [FUNC_WIDTH-1:0] {
        U_LI  = 4'b0011,  // Two words, full immediate
        U_LIL = 4'b0100   // Immediate in bits 15:12
    } u_func_e;

    // J-type function, bits 15:12
    typedef enum logic [FUNC_WIDTH-1:0] {
        J_JAL  = 4'b0000,
        J_JALR = 4'b0001
    } j_func_e;

    typedef enum logic [1:0] {
        SRC1_ZERO,
        SRC1_REG1,
        SRC1_IMM_B
    } src1_sel_e;

    typedef enum logic [2:0] {
        SRC2_ZERO,
        SRC2_REG1,
        SRC2_REG2,
        SRC2_IMM_A,
        SRC2_IMM_B,
        SRC2_PC_PREV,  // PC of the first word
        SRC2_PC_CUR
    } src2_sel_e;

    typedef enum logic {
        SRC3_ZERO,
        SRC3_REG1  // Store data
    } src3_sel_e;

    // Execute-stage actions
    typedef struct packed {
        logic branch_eq0;
        logic branch_gt0;
        logic branch_lt0;
        logic ialu_add;
        logic ialu_neg_src2;
        logic ialu_sll;
        logic ialu_sra;
        logic ialu_srl;
        logic incr_pc_is_res;
        logic jump_to_ialu_res;
        logic load_dmem;
        logic store_dmem;
        logic write_res_to_reg;
        logic write_src2_to_res;
    } act_t;

endpackage

// ==== verilog/decoder_top.sv ====
module decoder_top (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   flush,
    input  logic [decoder_pkg::WORD_WIDTH-1:0]     instr,
    input  logic [decoder_pkg::PC_WIDTH-1:0]       pc,
    input  logic [decoder_pkg::WORD_WIDTH-1:0]     src1,
    input  logic [decoder_pkg::WORD_WIDTH-1:0]     src2,
    output logic                                   act_branch_eq0,
    output logic                                   act_branch_gt0,
    output logic                                   act_branch_lt0,
    output logic                                   act_ialu_add,
    output logic                                   act_ialu_neg_src2,
    output logic                                   act_ialu_sll,
    output logic                                   act_ialu_sra,
    output logic                                   act_ialu_srl,
    output logic                                   act_incr_pc_is_res,
    output logic                                   act_jump_to_ialu_res,
    output logic                                   act_load_dmem,
    output logic                                   act_store_dmem,
    output logic                                   act_write_res_to_reg,
    output logic                                   act_write_src2_to_res,
    output logic [2:0]                             cycle_in_instr,
    output logic [decoder_pkg::WORD_WIDTH-1:0]     instr_out,
    output logic [decoder_pkg::PC_WIDTH-1:0]       pc_out,
    output logic [decoder_pkg::REG_IDX_WIDTH-1:0]  res_reg_idx,
    output logic [decoder_pkg::REG_IDX_WIDTH-1:0]  src1_reg_idx,
    output logic [decoder_pkg::REG_IDX_WIDTH-1:0]  src2_reg_idx,
    output logic [decoder_pkg::WORD_WIDTH-1:0]     src1_out,
    output logic [decoder_pkg::WORD_WIDTH-1:0]     src2_out,
    output logic [decoder_pkg::WORD_WIDTH-1:0]     src3_out
);
    import decoder_pkg::*;

    act_t act;

    decode_fields_if fields ();
    operand_sel_if   operands ();

    instr_capture u_capture (
        .clock        (clock),
        .reset        (reset),
        .instr        (instr),
        .pc           (pc),
        .fields       (fields.capture),
        .operands     (operands.capture),
        .instr_out    (instr_out),
        .pc_out       (pc_out),
        .res_reg_idx  (res_reg_idx),
        .src1_reg_idx (src1_reg_idx),
        .src2_reg_idx (src2_reg_idx)
    );

    decode_control u_control (
        .clock          (clock),
        .reset          (reset),
        .flush          (flush),
        .fields         (fields.control),
        .sel            (operands.control),
        .act            (act),
        .cycle_in_instr (cycle_in_instr)
    );

    operand_select u_select (
        .src1     (src1),
        .src2     (src2),
        .sel      (operands.select),
        .src1_out (src1_out),
        .src2_out (src2_out),
        .src3_out (src3_out)
    );

    assign act_branch_eq0        = act.branch_eq0;
    assign act_branch_gt0        = act.branch_gt0;
    assign act_branch_lt0        = act.branch_lt0;
    assign act_ialu_add          = act.ialu_add;
    assign act_ialu_neg_src2     = act.ialu_neg_src2;
    assign act_ialu_sll          = act.ialu_sll;
    assign act_ialu_sra          = act.ialu_sra;
    assign act_ialu_srl          = act.ialu_srl;
    assign act_incr_pc_is_res    = act.incr_pc_is_res;
    assign act_jump_to_ialu_res  = act.jump_to_ialu_res;
    assign act_load_dmem         = act.load_dmem;
    assign act_store_dmem        = act.store_dmem;
    assign act_write_res_to_reg  = act.write_res_to_reg;
    assign act_write_src2_to_res = act.write_src2_to_res;

endmodule

// ==== verilog/instr_capture.sv ====
module instr_capture (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [decoder_pkg::WORD_WIDTH-1:0]     instr,
    input  logic [decoder_pkg::PC_WIDTH-1:0]       pc,
    decode_fields_if.capture                       fields,
    operand_sel_if.capture                         operands,
    output logic [decoder_pkg::WORD_WIDTH-1:0]     instr_out,
    output logic [decoder_pkg::PC_WIDTH-1:0]       pc_out,
    output logic [decoder_pkg::REG_IDX_WIDTH-1:0]  res_reg_idx,
    output logic [decoder_pkg::REG_IDX_WIDTH-1:0]  src1_reg_idx,
    output logic [decoder_pkg::REG_IDX_WIDTH-1:0]  src2_reg_idx
);
    import decoder_pkg::*;

    logic [WORD_WIDTH-1:0] instr_q;
    logic [WORD_WIDTH-1:0] instr_q2;  // Word before the current one
    logic [PC_WIDTH-1:0]   pc_q;
    logic [PC_WIDTH-1:0]   pc_q2;
    logic [WORD_WIDTH-1:0] first_word;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            instr_q  <= '0;
            instr_q2 <= '0;
            pc_q     <= '0;
            pc_q2    <= '0;
        end else begin
            instr_q  <= instr;
            instr_q2 <= instr_q;
            pc_q     <= pc;
            pc_q2    <= pc_q;
        end
    end

    // Two-word instructions keep decoding the held first word
    assign first_word = fields.second_cycle ? instr_q2 : instr_q;

    assign fields.opcode = opcode_e'(first_word[3:0]);
    assign fields.s_func = s_func_e'(first_word[7:4]);
    assign fields.u_func = u_func_e'(first_word[11:8]);
    assign fields.j_func = j_func_e'(first_word[15:12]);

    assign operands.imm_a   = first_word[15:12];
    assign operands.imm_b   = instr_q;
    assign operands.pc_prev = pc_q2;
    assign operands.pc_cur  = pc_q;

    assign instr_out    = instr_q;
    assign pc_out       = pc_q;
    assign res_reg_idx  = first_word[7:4];
    assign src1_reg_idx = first_word[11:8];
    assign src2_reg_idx = first_word[15:12];

    // No instruction is longer than two words
    a_second_cycle_single: assert property (@(posedge clock) disable iff (reset)
        fields.second_cycle |=> !fields.second_cycle);

endmodule

// ==== verilog/operand_sel_if.sv ====
interface operand_sel_if;
    import decoder_pkg::*;

    src1_sel_e              src1_sel;
    src2_sel_e              src2_sel;
    src3_sel_e              src3_sel;
    logic [IMM_A_WIDTH-1:0] imm_a;
    logic [WORD_WIDTH-1:0]  imm_b;    // Second word
    logic [PC_WIDTH-1:0]    pc_prev;
    logic [PC_WIDTH-1:0]    pc_cur;

    modport control (output src1_sel, output src2_sel, output src3_sel);
    modport capture (output imm_a, output imm_b, output pc_prev, output pc_cur);
    modport select (
        input src1_sel, input src2_sel, input src3_sel,
        input imm_a, input imm_b, input pc_prev, input pc_cur
    );

endinterface

// ==== verilog/operand_select.sv ====
module operand_select (
    input  logic [decoder_pkg::WORD_WIDTH-1:0] src1,
    input  logic [decoder_pkg::WORD_WIDTH-1:0] src2,
    operand_sel_if.select                      sel,
    output logic [decoder_pkg::WORD_WIDTH-1:0] src1_out,
    output logic [decoder_pkg::WORD_WIDTH-1:0] src2_out,
    output logic [decoder_pkg::WORD_WIDTH-1:0] src3_out
);
    import decoder_pkg::*;

    logic [WORD_WIDTH-1:0] pc_prev_ext;
    logic [WORD_WIDTH-1:0] pc_cur_ext;
    logic [WORD_WIDTH-1:0] imm_a_ext;

    // Zero extension, no sign
    assign pc_prev_ext = {{(WORD_WIDTH - PC_WIDTH){1'b0}}, sel.pc_prev};
    assign pc_cur_ext  = {{(WORD_WIDTH - PC_WIDTH){1'b0}}, sel.pc_cur};
    assign imm_a_ext   = {{(WORD_WIDTH - IMM_A_WIDTH){1'b0}}, sel.imm_a};

    always_comb begin
        case (sel.src1_sel)
            SRC1_REG1:  src1_out = src1;
            SRC1_IMM_B: src1_out = sel.imm_b;
            default:    src1_out = '0;
        endcase

        case (sel.src2_sel)
            SRC2_REG1:    src2_out = src1;
            SRC2_REG2:    src2_out = src2;
            SRC2_IMM_A:   src2_out = imm_a_ext;
            SRC2_IMM_B:   src2_out = sel.imm_b;
            SRC2_PC_PREV: src2_out = pc_prev_ext;
            SRC2_PC_CUR:  src2_out = pc_cur_ext;
            default:      src2_out = '0;
        endcase

        src3_out = (sel.src3_sel == SRC3_REG1) ? src1 : '0;
    end

endmodule
